// File: filelist.f
+incdir+hdl
hdl/controllerPkg.sv
hdl/apbHostInterface.sv
hdl/instructionSequencer.sv
hdl/regfileAOutputLogic.sv
hdl/writebackOperandLatch.sv
hdl/regfileA.sv
hdl/regfileAControlTop.sv
tb/regfileAControlTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks sim.log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f filelist.f \
    --top-module regfileAControlTb -o regfileAControlSim > build.log 2>&1 \
    && { ./obj_dir/regfileAControlSim > sim.log 2>&1 || true; } \
    && grep -qx "TESTS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: tb/regfileAControlTb.sv
`default_nettype none

`include "regfileA_config.svh"

module regfileAControlTb;

    localparam int timeoutCycles = 60;

    logic                       clk;
    logic                       reset;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`DATA_WIDTH-1:0]     pwdata;
    logic [`DATA_WIDTH-1:0]     prdata;
    logic                       pready;
    logic                       pslverr;

    logic [`DATA_WIDTH-1:0] model [`REG_COUNT]; // Expected register contents.
    logic [`DATA_WIDTH-1:0] readValue;
    logic                   lastError;
    int                     lastWait;
    int                     errors;
    int                     protocolErrors;
    int                     completed; // Instructions past WRITEBACK.

    regfileAControlTop DUT (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #50 clk = ~clk;

    errorNeedsReady: assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
        else begin
            protocolErrors++;
            $display("pslverr was high while pready was low");
        end

    task automatic abortRun(input string reason);
        $display("Timeout: %s", reason);
        $display("Errors: %0d check, %0d protocol", errors, protocolErrors);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual == expected)
        else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic apbAccess(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input logic [`DATA_WIDTH-1:0] data);
        int cycles;
        @(posedge clk);
        psel    <= 1'b1; // Setup phase.
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!pready && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!pready) begin
            abortRun("pready never rose during an APB access");
        end
        lastWait  = cycles;
        lastError = pslverr;
        readValue = prdata;
        @(posedge clk); // Transfer completes here.
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr,
                            input logic [`DATA_WIDTH-1:0] data);
        apbAccess(1'b1, addr, data);
    endtask

    task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr);
        apbAccess(1'b0, addr, '0);
    endtask

    task automatic waitIdle(input string name);
        int polls;
        polls = 0;
        apbRead(8'h10);
        while (readValue[0] && polls < timeoutCycles) begin
            apbRead(8'h10);
            polls++;
        end
        if (readValue[0]) begin
            abortRun({name, " left the sequencer busy"});
        end
    endtask

    task automatic loadOperands(input logic [31:0] alu, input logic [31:0] load,
                                input logic [31:0] sys);
        apbWrite(8'h04, alu);
        apbWrite(8'h08, load);
        apbWrite(8'h0C, sys);
    endtask

    task automatic runInstruction(input string name, input controllerPkg::opcodes op,
                                  input logic [3:0] dest, input logic [15:0] imm);
        apbWrite(8'h00, {imm, 4'h0, dest, op});
        checkValue({name, " issue pslverr"}, 32'd0, {31'd0, lastError});
        waitIdle(name);
        completed++;
    endtask

    task automatic checkAllRegs(input string name);
        logic [`APB_ADDR_WIDTH-1:0] addr;
        for (int i = 0; i < `REG_COUNT; i++) begin
            addr = 8'h40 + 8'(i * 4);
            apbRead(addr);
            checkValue($sformatf("%s r%0d", name, i), model[i], readValue);
        end
    endtask

    initial begin
        logic [31:0] aluValue;
        logic [31:0] loadValue;
        logic [31:0] sysValue;
        logic [15:0] immValue;
        clk            = 1'b0;
        reset          = 1'b1;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        errors         = 0;
        protocolErrors = 0;
        completed      = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        void'($urandom(32'h7d36_7305));
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        apbRead(8'h10);
        checkValue("reset status", 32'd0, readValue);
        checkAllRegs("reset");

        aluValue = $urandom;
        loadOperands(aluValue, $urandom, $urandom);
        runInstruction("add", controllerPkg::ADD_R, 4'd1, 16'h0000);
        model[1] = aluValue;
        aluValue = $urandom;
        loadOperands(aluValue, $urandom, $urandom);
        runInstruction("sub", controllerPkg::SUB_I, 4'd2, 16'h1234);
        model[2] = aluValue;
        aluValue = $urandom;
        loadOperands(aluValue, $urandom, $urandom);
        runInstruction("xor", controllerPkg::XOR_R, 4'd3, 16'h0000);
        model[3] = aluValue;
        loadOperands($urandom, $urandom, $urandom);
        runInstruction("nop", controllerPkg::NOP, 4'd1, 16'hffff); // No register changes.
        checkAllRegs("alu and nop");

        loadValue = $urandom | 32'h0000_8080; // Sign bits set.
        loadOperands(32'd0, loadValue, 32'd0);
        runInstruction("ldd", controllerPkg::LDD_RR, 4'd4, 16'h0000);
        model[4] = loadValue;
        runInstruction("ldbs", controllerPkg::LDBS_RR, 4'd5, 16'h0000);
        model[5] = {{24{loadValue[7]}}, loadValue[7:0]};
        runInstruction("ldws", controllerPkg::LDWS_RR, 4'd6, 16'h0000);
        model[6] = {{16{loadValue[15]}}, loadValue[15:0]};
        runInstruction("ldbu", controllerPkg::LDBU_RR, 4'd7, 16'h0000);
        model[7] = {24'd0, loadValue[7:0]};
        runInstruction("ldwu", controllerPkg::LDWU_RR, 4'd8, 16'h0000);
        model[8] = {16'd0, loadValue[15:0]};
        loadValue = $urandom & 32'hffff_7f7f;
        loadOperands(32'd0, loadValue, 32'd0);
        runInstruction("ldbs positive", controllerPkg::LDBS_RR, 4'd9, 16'h0000);
        model[9] = {24'd0, loadValue[7:0]};
        checkAllRegs("loads");

        sysValue = $urandom;
        loadOperands(32'd0, 32'd0, sysValue);
        runInstruction("lsr", controllerPkg::LSR_R, 4'd10, 16'h0000);
        model[10] = sysValue;
        immValue  = 16'($urandom);
        runInstruction("mui", controllerPkg::MUI_I, 4'd11, immValue);
        model[11] = {immValue, 16'h0000};
        model[15] = 32'(4 * completed + 4); // Link gets pc plus 4.
        runInstruction("brl", controllerPkg::BRL_RR, 4'd12, 16'h0000);
        checkAllRegs("lsr mui brl");

        aluValue = $urandom;
        loadOperands(aluValue, 32'd0, 32'd0);
        apbWrite(8'h14, 32'd1);
        model[13] = aluValue;
        model[14] = 32'(4 * completed + 8); // Pc already bumped at WRITEBACK.
        runInstruction("interrupt add", controllerPkg::ADD_R, 4'd13, 16'h0000);
        checkAllRegs("interrupt");

        aluValue  = $urandom;
        loadValue = $urandom;
        loadOperands(aluValue, loadValue, 32'd0);
        apbWrite(8'h00, {16'h0000, 4'h0, 4'd1, controllerPkg::ADD_R});
        apbWrite(8'h00, {16'h0000, 4'h0, 4'd2, controllerPkg::LDWU_RR});
        checkValue("backpressure stall", 32'd1, 32'(lastWait > 5));
        waitIdle("backpressure");
        completed += 2;
        model[1] = aluValue;
        model[2] = {16'd0, loadValue[15:0]};

        aluValue = $urandom;
        loadOperands(aluValue, 32'd0, 32'd0);
        apbWrite(8'h00, {16'h0000, 4'h0, 4'd3, controllerPkg::XOR_R});
        apbWrite(8'h10, 32'h0000_0002);
        repeat (5) begin
            apbRead(8'h10);
            checkValue("frozen status", 32'h0000_0003, readValue);
        end
        apbWrite(8'h10, 32'h0000_0000);
        waitIdle("freeze");
        completed++;
        model[3] = aluValue;
        checkAllRegs("backpressure and freeze");

        apbWrite(8'h18, 32'hdead_beef);
        checkValue("unmapped write pslverr", 32'd1, {31'd0, lastError});
        apbRead(8'h04);
        checkValue("write-only read pslverr", 32'd1, {31'd0, lastError});
        apbRead(8'h80);
        checkValue("unmapped read pslverr", 32'd1, {31'd0, lastError});
        apbRead(8'h40);
        checkValue("mapped read pslverr", 32'd0, {31'd0, lastError});

        $display("Errors: %0d check, %0d protocol", errors, protocolErrors);
        if (errors == 0 && protocolErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/regfileAControlTop.sv
`default_nettype none

`include "regfileA_config.svh"

module regfileAControlTop (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`APB_ADDR_WIDTH-1:0]    paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`DATA_WIDTH-1:0]        pwdata,
    output logic [`DATA_WIDTH-1:0]        prdata,
    output logic                          pready,
    output logic                          pslverr
);

    logic                          issueValid;
    logic [`DATA_WIDTH-1:0]        instructionWord;
    logic [`DATA_WIDTH-1:0]        aluResult;
    logic [`DATA_WIDTH-1:0]        loadData;
    logic [`DATA_WIDTH-1:0]        sysregValue;
    logic                          freeze;
    logic                          interruptRequest;
    logic [`REG_INDEX_WIDTH-1:0]   readIndex;
    logic [`DATA_WIDTH-1:0]        readData;
    controllerPkg::states          state;
    controllerPkg::opcodes         opcode;
    logic [`REG_INDEX_WIDTH-1:0]   destination;
    logic [`DATA_WIDTH/2-1:0]      immediate;
    logic [`DATA_WIDTH-1:0]        nextPc;
    logic                          busy;
    logic                          advance;
    controllerPkg::controlBus      regfileAControl;
    logic [`DATA_WIDTH-1:0]        operand;

    apbHostInterface hostIf (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .busy, .readData,
        .issueValid, .instructionWord, .aluResult, .loadData, .sysregValue,
        .freeze, .interruptRequest, .readIndex
    );

    instructionSequencer sequencer (
        .clk, .reset, .issueValid, .instructionWord, .freeze, .interruptRequest,
        .state, .opcode, .destination, .immediate, .nextPc, .busy, .advance
    );

    // Both side blocks step on the same enable so code and word stay paired.
    regfileAOutputLogic outputLogic (
        .clk, .reset, .enable(advance), .instruction(opcode), .state,
        .regfileAControl
    );

    writebackOperandLatch operandLatch (
        .clk, .reset, .enable(advance), .state, .aluResult, .loadData,
        .sysregValue, .immediate, .nextPc, .operand
    );

    regfileA regs (
        .clk, .reset, .enable(advance), .control(regfileAControl), .operand,
        .destination, .readIndex, .readData
    );

endmodule

`default_nettype wire

// File: hdl/regfileA.sv
`default_nettype none

`include "regfileA_config.svh"

module regfileA (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enable,
    input  controllerPkg::controlBus      control,
    input  logic [`DATA_WIDTH-1:0]        operand,
    input  logic [`REG_INDEX_WIDTH-1:0]   destination,
    input  logic [`REG_INDEX_WIDTH-1:0]   readIndex,
    output logic [`DATA_WIDTH-1:0]        readData
);

    localparam int halfWidth = `DATA_WIDTH / 2;

    logic [`DATA_WIDTH-1:0]      regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]      writeValue;
    logic [`REG_INDEX_WIDTH-1:0] writeIndex;

    always_comb begin
        case (control)
            controllerPkg::AREG_DRL:  writeValue = {operand[halfWidth-1:0], {halfWidth{1'b0}}};
            controllerPkg::SBYTE_DRL: writeValue = {{(`DATA_WIDTH-8){operand[7]}}, operand[7:0]};
            controllerPkg::SWORD_DRL: writeValue = {{halfWidth{operand[halfWidth-1]}},
                                                    operand[halfWidth-1:0]};
            controllerPkg::UBYTE_DRL: writeValue = {{(`DATA_WIDTH-8){1'b0}}, operand[7:0]};
            controllerPkg::UWORD_DRL: writeValue = {{halfWidth{1'b0}}, operand[halfWidth-1:0]};
            default:                  writeValue = operand;
        endcase
    end

    always_comb begin
        case (control)
            controllerPkg::NEXTPC_LR:  writeIndex = `REG_INDEX_WIDTH'(`LINK_REG);
            controllerPkg::NEXTPC_EPC: writeIndex = `REG_INDEX_WIDTH'(`EPC_REG);
            default:                   writeIndex = destination;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (enable && control != controllerPkg::NO_OP) begin
            regs[writeIndex] <= writeValue;
        end
    end

    assign readData = regs[readIndex]; // Asynchronous read port.

endmodule

`default_nettype wire

// File: hdl/writebackOperandLatch.sv
`default_nettype none

`include "regfileA_config.svh"

module writebackOperandLatch (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  controllerPkg::states        state,
    input  logic [`DATA_WIDTH-1:0]      aluResult,
    input  logic [`DATA_WIDTH-1:0]      loadData,
    input  logic [`DATA_WIDTH-1:0]      sysregValue,
    input  logic [`DATA_WIDTH/2-1:0]    immediate,
    input  logic [`DATA_WIDTH-1:0]      nextPc,
    output logic [`DATA_WIDTH-1:0]      operand
);

    logic [`DATA_WIDTH-1:0] operandNext;

    always_comb begin
        case (state)
            controllerPkg::DECODE:    operandNext = sysregValue;
            controllerPkg::LOAD:      operandNext = {{(`DATA_WIDTH/2){1'b0}}, immediate};
            controllerPkg::EXECUTE0,
            controllerPkg::INTERRUPT: operandNext = nextPc;
            controllerPkg::EXECUTE1:  operandNext = aluResult;
            controllerPkg::MEMORY3:   operandNext = loadData;
            default:                  operandNext = operand; // Keep last word.
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            operand <= '0;
        end else if (enable) begin
            operand <= operandNext;
        end
    end

endmodule

`default_nettype wire

// File: hdl/regfileAOutputLogic.sv
`default_nettype none

module regfileAOutputLogic (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     enable,
    input  controllerPkg::opcodes    instruction,
    input  controllerPkg::states     state,
    output controllerPkg::controlBus regfileAControl
);

    controllerPkg::controlBus regfileAControlNext;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regfileAControl <= controllerPkg::NO_OP;
        end else if (enable) begin
            regfileAControl <= regfileAControlNext; // Holds while stalled.
        end
    end

    always_comb begin
        regfileAControlNext = controllerPkg::NO_OP;

        case (state)
            controllerPkg::DECODE: begin
                if (instruction == controllerPkg::LSR_R) begin
                    regfileAControlNext = controllerPkg::SYSREG_DRL;
                end
            end

            controllerPkg::LOAD: begin
                if (instruction == controllerPkg::MUI_I) begin
                    regfileAControlNext = controllerPkg::AREG_DRL;
                end
            end

            controllerPkg::EXECUTE0: begin
                if (instruction == controllerPkg::BRL_RR) begin
                    regfileAControlNext = controllerPkg::NEXTPC_LR;
                end
            end

            controllerPkg::EXECUTE1: begin
                case (instruction)
                    controllerPkg::ADD_R,
                    controllerPkg::SUB_I,
                    controllerPkg::XOR_R:   regfileAControlNext = controllerPkg::RESULT_DRL;
                    default:                regfileAControlNext = controllerPkg::NO_OP;
                endcase
            end

            // Load width picks the extension.
            controllerPkg::MEMORY3: begin
                case (instruction)
                    controllerPkg::LDD_RR:  regfileAControlNext = controllerPkg::DWORD_DRL;
                    controllerPkg::LDBS_RR: regfileAControlNext = controllerPkg::SBYTE_DRL;
                    controllerPkg::LDWS_RR: regfileAControlNext = controllerPkg::SWORD_DRL;
                    controllerPkg::LDBU_RR: regfileAControlNext = controllerPkg::UBYTE_DRL;
                    controllerPkg::LDWU_RR: regfileAControlNext = controllerPkg::UWORD_DRL;
                    default:                regfileAControlNext = controllerPkg::NO_OP;
                endcase
            end

            controllerPkg::INTERRUPT: begin
                regfileAControlNext = controllerPkg::NEXTPC_EPC;
            end

            default: begin
                regfileAControlNext = controllerPkg::NO_OP;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/instructionSequencer.sv
`default_nettype none

`include "regfileA_config.svh"

module instructionSequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          issueValid,
    input  logic [`DATA_WIDTH-1:0]        instructionWord,
    input  logic                          freeze,
    input  logic                          interruptRequest,
    output controllerPkg::states          state,
    output controllerPkg::opcodes         opcode,
    output logic [`REG_INDEX_WIDTH-1:0]   destination,
    output logic [`DATA_WIDTH/2-1:0]      immediate,
    output logic [`DATA_WIDTH-1:0]        nextPc,
    output logic                          busy,
    output logic                          advance
);

    logic [`DATA_WIDTH-1:0] instructionReg;
    logic [`DATA_WIDTH-1:0] pc;
    logic                   interruptPending;
    controllerPkg::states   stateNext;

    assign advance     = ~freeze;
    assign busy        = (state != controllerPkg::IDLE);
    assign opcode      = controllerPkg::opcodes'(instructionReg[7:0]);
    assign destination = instructionReg[8 +: `REG_INDEX_WIDTH];
    assign immediate   = instructionReg[`DATA_WIDTH-1 -: `DATA_WIDTH/2];
    assign nextPc      = pc + 4;

    always_comb begin
        case (state)
            controllerPkg::IDLE:      stateNext = issueValid ? controllerPkg::DECODE
                                                             : controllerPkg::IDLE;
            controllerPkg::DECODE:    stateNext = controllerPkg::LOAD;
            controllerPkg::LOAD:      stateNext = controllerPkg::EXECUTE0;
            controllerPkg::EXECUTE0:  stateNext = controllerPkg::EXECUTE1;
            controllerPkg::EXECUTE1:  stateNext = controllerPkg::MEMORY0;
            controllerPkg::MEMORY0:   stateNext = controllerPkg::MEMORY1;
            controllerPkg::MEMORY1:   stateNext = controllerPkg::MEMORY2;
            controllerPkg::MEMORY2:   stateNext = controllerPkg::MEMORY3;
            controllerPkg::MEMORY3:   stateNext = controllerPkg::WRITEBACK;
            controllerPkg::WRITEBACK: stateNext = interruptPending ? controllerPkg::INTERRUPT
                                                                   : controllerPkg::IDLE;
            default:                  stateNext = controllerPkg::IDLE;
        endcase
    end

    // Issue is taken in IDLE even while frozen.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= controllerPkg::IDLE;
        end else if (advance || state == controllerPkg::IDLE) begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (state == controllerPkg::IDLE && issueValid) begin
            instructionReg <= instructionWord;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc               <= '0;
            interruptPending <= 1'b0;
        end else begin
            if (advance && state == controllerPkg::WRITEBACK) begin
                pc <= nextPc;
            end
            if (advance && state == controllerPkg::INTERRUPT) begin
                interruptPending <= 1'b0;
            end
            if (interruptRequest) begin
                interruptPending <= 1'b1; // A new request wins over the clear.
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/apbHostInterface.sv
`default_nettype none

`include "regfileA_config.svh"

module apbHostInterface (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`APB_ADDR_WIDTH-1:0]    paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`DATA_WIDTH-1:0]        pwdata,
    output logic [`DATA_WIDTH-1:0]        prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          busy,
    input  logic [`DATA_WIDTH-1:0]        readData,
    output logic                          issueValid,
    output logic [`DATA_WIDTH-1:0]        instructionWord,
    output logic [`DATA_WIDTH-1:0]        aluResult,
    output logic [`DATA_WIDTH-1:0]        loadData,
    output logic [`DATA_WIDTH-1:0]        sysregValue,
    output logic                          freeze,
    output logic                          interruptRequest,
    output logic [`REG_INDEX_WIDTH-1:0]   readIndex
);

    localparam logic [`APB_ADDR_WIDTH-1:0] instrAddr   = 'h00;
    localparam logic [`APB_ADDR_WIDTH-1:0] aluAddr     = 'h04;
    localparam logic [`APB_ADDR_WIDTH-1:0] loadAddr    = 'h08;
    localparam logic [`APB_ADDR_WIDTH-1:0] sysregAddr  = 'h0C;
    localparam logic [`APB_ADDR_WIDTH-1:0] statusAddr  = 'h10;
    localparam logic [`APB_ADDR_WIDTH-1:0] irqAddr     = 'h14;
    localparam logic [`APB_ADDR_WIDTH-1:0] regFirst    = 'h40;
    localparam logic [`APB_ADDR_WIDTH-1:0] regLast     = 'h7C;

    logic accessPhase;
    logic isRegRead;
    logic mapped;
    logic stall;
    logic writeFire;

    assign accessPhase = psel & penable;
    assign isRegRead   = (paddr >= regFirst) && (paddr <= regLast) && (paddr[1:0] == 2'b00);
    assign readIndex   = paddr[2 +: `REG_INDEX_WIDTH]; // Word offset within r0..r15.

    // Write-only offsets are errors on a read, and the reverse.
    assign mapped = pwrite ? (paddr == instrAddr) || (paddr == aluAddr) ||
                             (paddr == loadAddr) || (paddr == sysregAddr) ||
                             (paddr == statusAddr) || (paddr == irqAddr)
                           : (paddr == statusAddr) || isRegRead;

    assign stall   = pwrite && (paddr == instrAddr) && busy; // Hold INSTR until idle.
    assign pready  = accessPhase & ~stall;
    assign pslverr = pready & ~mapped;

    assign writeFire        = pready & pwrite & mapped;
    assign issueValid       = writeFire && (paddr == instrAddr);
    assign instructionWord  = pwdata;
    assign interruptRequest = writeFire && (paddr == irqAddr) && pwdata[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            freeze <= 1'b0;
        end else if (writeFire && (paddr == statusAddr)) begin
            freeze <= pwdata[1]; // Busy bit is read only.
        end
    end

    always_ff @(posedge clk) begin
        if (writeFire && (paddr == aluAddr)) begin
            aluResult <= pwdata;
        end
        if (writeFire && (paddr == loadAddr)) begin
            loadData <= pwdata;
        end
        if (writeFire && (paddr == sysregAddr)) begin
            sysregValue <= pwdata;
        end
    end

    always_comb begin
        prdata = '0;
        if (accessPhase && !pwrite) begin
            if (paddr == statusAddr) begin
                prdata[1:0] = {freeze, busy};
            end else if (isRegRead) begin
                prdata = readData;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/controllerPkg.sv
`default_nettype none

package controllerPkg;

    // Low byte of the instruction word.
    typedef enum logic [7:0] {
        NOP     = 8'h00,
        LSR_R   = 8'h01,
        MUI_I   = 8'h02,
        BRL_RR  = 8'h03,
        ADD_R   = 8'h04,
        SUB_I   = 8'h05,
        XOR_R   = 8'h06,
        LDD_RR  = 8'h07,
        LDBS_RR = 8'h08,
        LDWS_RR = 8'h09,
        LDBU_RR = 8'h0A,
        LDWU_RR = 8'h0B
    } opcodes;

    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        DECODE    = 4'd1,
        LOAD      = 4'd2,
        EXECUTE0  = 4'd3,
        EXECUTE1  = 4'd4,
        MEMORY0   = 4'd5,
        MEMORY1   = 4'd6,
        MEMORY2   = 4'd7,
        MEMORY3   = 4'd8,
        WRITEBACK = 4'd9,
        INTERRUPT = 4'd10
    } states;

    // Write port source and extension for register file A.
    typedef enum logic [3:0] {
        NO_OP      = 4'd0,
        SYSREG_DRL = 4'd1,
        AREG_DRL   = 4'd2,
        NEXTPC_LR  = 4'd3,
        RESULT_DRL = 4'd4,
        DWORD_DRL  = 4'd5,
        SBYTE_DRL  = 4'd6,
        SWORD_DRL  = 4'd7,
        UBYTE_DRL  = 4'd8,
        UWORD_DRL  = 4'd9,
        NEXTPC_EPC = 4'd10
    } controlBus;

endpackage

`default_nettype wire

// File: hdl/regfileA_config.svh
`ifndef REGFILEA_CONFIG_SVH
`define REGFILEA_CONFIG_SVH

// Datapath word width.
`define DATA_WIDTH 32

// Register file A geometry.
`define REG_COUNT 16
`define REG_INDEX_WIDTH 4

// Fixed destinations for branch-and-link and interrupt entry.
`define LINK_REG 15
`define EPC_REG 14

// Byte address width of the APB slave.
`define APB_ADDR_WIDTH 8

`endif
